//--- bench/tb_vectors.svh
// Analog path test table with reference model for ADC decode, P term, mixing and DAC code
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

localparam int REF_SHIFT = 10;    // Controller shift at its default
localparam int REF_MAX   = 8191;
localparam int REF_MIN   = -8192;

// Clip to the 14-bit sample range
function automatic int clip_sample(input longint v);
  if (v > REF_MAX)
    return REF_MAX;
  if (v < REF_MIN)
    return REF_MIN;
  return int'(v);
endfunction

// Negative slope, code 0x1FFF is zero, 0 is full scale positive
function automatic int raw_to_value(input logic [15:0] raw);
  return REF_MAX - int'(raw[15:2]);  // Reserved LSBs dropped
endfunction

function automatic logic [13:0] value_to_code(input int s);
  int c;
  c = REF_MAX - s;  // Same slope on the DAC side
  return c[13:0];
endfunction

// Level plus clipped gain * error, clipped again
function automatic int expected_sum(input int smp, input int setpt, input int gain,
                                    input int level);
  longint prod;
  int     p_val;
  prod  = longint'(setpt - smp) * longint'(gain);
  p_val = clip_sample(prod >>> REF_SHIFT);  // Floor shift
  return clip_sample(longint'(level) + longint'(p_val));
endfunction

//////////////////////////////////////////////////
// Stimulus table
//////////////////////////////////////////////////

localparam int MAX_ROWS = 16;

string       row_name  [MAX_ROWS];
bit          row_loop  [MAX_ROWS];  // Digital loopback bit
logic [15:0] row_adc_a [MAX_ROWS];
logic [15:0] row_adc_b [MAX_ROWS];
int          row_lvl_a [MAX_ROWS];
int          row_lvl_b [MAX_ROWS];
int          row_sp_a  [MAX_ROWS];
int          row_sp_b  [MAX_ROWS];
int          row_g_a   [MAX_ROWS];
int          row_g_b   [MAX_ROWS];
logic [13:0] row_exp_a [MAX_ROWS];  // Expected DAC codes
logic [13:0] row_exp_b [MAX_ROWS];
int          n_rows     = 0;
int          prev_sum_a = 0;        // Last expected sums, fed back in loopback
int          prev_sum_b = 0;

// Append one row; random_adc replaces the given ADC words
task automatic add_row(input string name, input bit loop, input bit random_adc,
                       input logic [15:0] adc_a, input logic [15:0] adc_b,
                       input int lvl_a, input int lvl_b, input int sp_a, input int sp_b,
                       input int g_a, input int g_b);
  int smp_a;
  int smp_b;
  int sum_a;
  int sum_b;
  row_name[n_rows]  = name;
  row_loop[n_rows]  = loop;
  row_adc_a[n_rows] = random_adc ? 16'($urandom) : adc_a;
  row_adc_b[n_rows] = random_adc ? 16'($urandom) : adc_b;
  row_lvl_a[n_rows] = lvl_a;
  row_lvl_b[n_rows] = lvl_b;
  row_sp_a[n_rows]  = sp_a;
  row_sp_b[n_rows]  = sp_b;
  row_g_a[n_rows]   = g_a;
  row_g_b[n_rows]   = g_b;
  // Loopback takes the earlier DAC sum instead of the converter
  smp_a = loop ? prev_sum_a : raw_to_value(row_adc_a[n_rows]);
  smp_b = loop ? prev_sum_b : raw_to_value(row_adc_b[n_rows]);
  sum_a = expected_sum(smp_a, sp_a, g_a, lvl_a);
  sum_b = expected_sum(smp_b, sp_b, g_b, lvl_b);
  row_exp_a[n_rows] = value_to_code(sum_a);
  row_exp_b[n_rows] = value_to_code(sum_b);
  prev_sum_a = sum_a;
  prev_sum_b = sum_b;
  n_rows++;
endtask

task automatic build_table();
  //      name            loop rnd adc_a     adc_b     lvl_a  lvl_b  sp_a   sp_b   g_a     g_b
  add_row("gen_mid",      0,   1,  16'h0000, 16'h0000, 1234,  -4321, 777,   -777,  0,      0);
  add_row("gen_full",     0,   1,  16'h0000, 16'h0000, 8191,  -8192, 100,   200,   0,      0);
  add_row("p_small",      0,   0,  16'h6000, 16'h9000, 500,   -300,  1000,  -1000, 2048,   -1024);
  add_row("p_unity",      0,   0,  16'h7FFC, 16'h8000, 0,     100,   3000,  -2500, 1024,   1024);
  add_row("sat_hi_lo",    0,   0,  16'h7FFC, 16'h7FFC, 8000,  -8000, 4000,  4000,  16384,  -16384);
  add_row("sat_lo_hi",    0,   0,  16'h7FFC, 16'h7FFC, -8000, 8000,  -4000, -4000, 16384,  -16384);
  add_row("loop_first",   1,   1,  16'h0000, 16'h0000, 2222,  -3333, 500,   -500,  0,      0);
  // Setpoint equals level, the looped sum holds still while random ADC words would not
  add_row("loop_second",  1,   1,  16'h0000, 16'h0000, 2222,  -3333, 2222,  -3333, 1024,   -2048);
  add_row("p_after_loop", 0,   0,  16'h6000, 16'h9000, 500,   -300,  1000,  -1000, 2048,   -1024);
  add_row("p_neg_err",    0,   0,  16'h1234, 16'hC1F0, -1500, 2500,  -200,  300,   -3000,  700);
endtask

`endif

//--- bench/tb_analog.sv
// Testbench for the analog path, register checks and table-driven datapath checks
`default_nettype none

module tb_analog;

  localparam int DRV      = 2;   // Drive delay after the rising edge
  localparam int ACK_WAIT = 8;   // Bus ack timeout in cycles

  logic        adc_clk;
  logic        rst_i;
  logic [15:0] adc_dat_a;
  logic [15:0] adc_dat_b;
  logic [7:0]  bus_addr;
  logic [31:0] bus_wdata;
  logic        bus_wen;
  logic        bus_ren;
  logic [31:0] bus_rdata;
  logic        bus_ack;
  logic        bus_err;
  logic [13:0] dac_a;
  logic [13:0] dac_b;

  `include "tb_vectors.svh"

  analog_top i_dut (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_wen_i   (bus_wen),
    .bus_ren_i   (bus_ren),
    .bus_rdata_o (bus_rdata),
    .bus_ack_o   (bus_ack),
    .bus_err_o   (bus_err),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b)
  );

  always #20 adc_clk = ~adc_clk;  // 40 unit period

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else fail_run($sformatf("error %s: expected 0x%08h, actual 0x%08h", name, exp, act));
  endtask

  // Ack comes one edge after the pulse
  task automatic wait_ack(input string name);
    int waited;
    waited = 0;
    while (!bus_ack && waited < ACK_WAIT)
    begin
      @(posedge adc_clk);
      #DRV;
      waited++;
    end
    assert (bus_ack)
    else fail_run($sformatf("%s: no bus ack within %0d cycles", name, ACK_WAIT));
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err, input string name);
    @(posedge adc_clk);
    #DRV;
    bus_addr  = addr;
    bus_wdata = data;
    bus_wen   = 1'b1;  // One-cycle pulse
    @(posedge adc_clk);
    #DRV;
    bus_wen   = 1'b0;
    wait_ack(name);
    check_value({name, "_err"}, exp_err, bus_err);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                          input logic exp_err, input string name);
    @(posedge adc_clk);
    #DRV;
    bus_addr = addr;
    bus_ren  = 1'b1;
    @(posedge adc_clk);
    #DRV;
    bus_ren  = 1'b0;
    wait_ack(name);
    check_value({name, "_err"}, exp_err, bus_err);
    data = bus_rdata;  // Valid with ack
  endtask

  // Program one row, drive its ADC words, check after the pipeline
  task automatic apply_row(input int i);
    write_reg(rp_analog_pkg::REG_CFG, {31'b0, row_loop[i]}, 1'b0, {row_name[i], "_cfg"});
    write_reg(rp_analog_pkg::REG_LEVEL_A, row_lvl_a[i], 1'b0, {row_name[i], "_lvl_a"});
    write_reg(rp_analog_pkg::REG_LEVEL_B, row_lvl_b[i], 1'b0, {row_name[i], "_lvl_b"});
    write_reg(rp_analog_pkg::REG_SETPT_A, row_sp_a[i], 1'b0, {row_name[i], "_sp_a"});
    write_reg(rp_analog_pkg::REG_SETPT_B, row_sp_b[i], 1'b0, {row_name[i], "_sp_b"});
    write_reg(rp_analog_pkg::REG_GAIN_A, row_g_a[i], 1'b0, {row_name[i], "_g_a"});
    write_reg(rp_analog_pkg::REG_GAIN_B, row_g_b[i], 1'b0, {row_name[i], "_g_b"});
    @(posedge adc_clk);
    #DRV;
    adc_dat_a = row_adc_a[i];
    adc_dat_b = row_adc_b[i];
    repeat (3) @(posedge adc_clk);  // Capture, control, mix
    #DRV;
    check_value({row_name[i], "_dac_a"}, row_exp_a[i], dac_a);
    check_value({row_name[i], "_dac_b"}, row_exp_b[i], dac_b);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rd;
    adc_clk   = 1'b0;
    rst_i     = 1'b1;
    adc_dat_a = 16'h0000;
    adc_dat_b = 16'h0000;
    bus_addr  = 8'h00;
    bus_wdata = 32'h0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    void'($urandom(32'ha207_1852));  // Seed once
    build_table();

    repeat (16) @(posedge adc_clk);
    #DRV;
    rst_i = 1'b0;

    // Reset state, signed zero on both DACs
    check_value("reset_dac_a", 32'h1FFF, dac_a);
    check_value("reset_dac_b", 32'h1FFF, dac_b);
    read_reg(rp_analog_pkg::REG_ID, rd, 1'b0, "id_read");
    check_value("id_value", rp_analog_pkg::ID_VALUE, rd);

    // Readback, sign bit of the field fills the upper bits
    write_reg(rp_analog_pkg::REG_LEVEL_A, 32'h0000_2ABC, 1'b0, "rb_level_a_wr");
    read_reg(rp_analog_pkg::REG_LEVEL_A, rd, 1'b0, "rb_level_a_rd");
    check_value("rb_level_a", 32'hFFFF_EABC, rd);
    write_reg(rp_analog_pkg::REG_SETPT_B, 32'h0000_1555, 1'b0, "rb_setpt_b_wr");
    read_reg(rp_analog_pkg::REG_SETPT_B, rd, 1'b0, "rb_setpt_b_rd");
    check_value("rb_setpt_b", 32'h0000_1555, rd);
    write_reg(rp_analog_pkg::REG_GAIN_A, 32'h0000_8001, 1'b0, "rb_gain_a_wr");
    read_reg(rp_analog_pkg::REG_GAIN_A, rd, 1'b0, "rb_gain_a_rd");
    check_value("rb_gain_a", 32'hFFFF_8001, rd);
    write_reg(rp_analog_pkg::REG_CFG, 32'hFFFF_FFFF, 1'b0, "rb_cfg_wr");
    read_reg(rp_analog_pkg::REG_CFG, rd, 1'b0, "rb_cfg_rd");
    check_value("rb_cfg", 32'h0000_0001, rd);  // Only the loopback bit

    // Error responses
    read_reg(8'h20, rd, 1'b1, "unmapped_read");
    write_reg(8'h24, 32'h1234_5678, 1'b1, "unmapped_write");
    write_reg(rp_analog_pkg::REG_ID, 32'h0, 1'b1, "id_write");
    read_reg(rp_analog_pkg::REG_ID, rd, 1'b0, "id_reread");
    check_value("id_kept", rp_analog_pkg::ID_VALUE, rd);

    for (int i = 0; i < n_rows; i++)
      apply_row(i);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
hw/rp_analog_pkg.sv
hw/housekeeping_regs.sv
hw/adc_frontend.sv
hw/p_controller.sv
hw/dac_mixer.sv
hw/analog_top.sv
bench/tb_analog.sv

//--- hw/adc_frontend.sv
// ADC capture with offset-code conversion and digital loopback select
`default_nettype none

module adc_frontend (
  input  wire                                       adc_clk,
  input  wire                                       rst_i,
  input  wire  [rp_analog_pkg::ADC_RAW_W-1:0]       adc_dat_a_i,     // Raw ADC word A
  input  wire  [rp_analog_pkg::ADC_RAW_W-1:0]       adc_dat_b_i,     // Raw ADC word B
  input  wire                                       digital_loop_i,  // Take DAC sums instead
  input  rp_analog_pkg::sample_t                    loop_a_i,
  input  rp_analog_pkg::sample_t                    loop_b_i,
  output rp_analog_pkg::sample_t                    sample_a_o,
  output rp_analog_pkg::sample_t                    sample_b_o
);

  localparam int RAW_W = rp_analog_pkg::ADC_RAW_W;
  localparam int SMP_W = rp_analog_pkg::SAMPLE_W;

  rp_analog_pkg::sample_t conv_a;  // Converted ADC word, before the mux
  rp_analog_pkg::sample_t conv_b;

  // Upper bits only, the two LSBs are reserved on a 14-bit converter
  assign conv_a = rp_analog_pkg::code_to_sample(adc_dat_a_i[RAW_W-1 -: SMP_W]);
  assign conv_b = rp_analog_pkg::code_to_sample(adc_dat_b_i[RAW_W-1 -: SMP_W]);

  //////////////////////////////////////////////////
  // Single input register stage
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      sample_a_o <= '0;
      sample_b_o <= '0;
    end
    else if (digital_loop_i)
    begin
      // Loopback, previous DAC sum replaces the converter
      sample_a_o <= loop_a_i;
      sample_b_o <= loop_b_i;
    end
    else
    begin
      sample_a_o <= conv_a;
      sample_b_o <= conv_b;
    end
  end

endmodule

`default_nettype wire

//--- hw/analog_top.sv
// Analog path top, bus registers feeding ADC capture, P control and DAC mixer
`default_nettype none

module analog_top #(
  parameter int GAIN_SHIFT = 10  // Passed to the controller
) (
  input  wire                                   adc_clk,
  input  wire                                   rst_i,
  // ADC words, negative-slope offset code
  input  wire  [rp_analog_pkg::ADC_RAW_W-1:0]   adc_dat_a_i,
  input  wire  [rp_analog_pkg::ADC_RAW_W-1:0]   adc_dat_b_i,
  // System bus
  input  wire  [rp_analog_pkg::BUS_AW-1:0]      bus_addr_i,
  input  wire  [rp_analog_pkg::BUS_DW-1:0]      bus_wdata_i,
  input  wire                                   bus_wen_i,
  input  wire                                   bus_ren_i,
  output wire  [rp_analog_pkg::BUS_DW-1:0]      bus_rdata_o,
  output wire                                   bus_ack_o,
  output wire                                   bus_err_o,
  // DAC codes, one port per channel
  output rp_analog_pkg::dac_code_t              dac_a_o,
  output rp_analog_pkg::dac_code_t              dac_b_o
);

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  wire                    digital_loop;
  rp_analog_pkg::sample_t level_a, level_b;    // Generator levels
  rp_analog_pkg::sample_t setpt_a, setpt_b;
  rp_analog_pkg::gain_t   gain_a, gain_b;
  rp_analog_pkg::sample_t sample_a, sample_b;  // Front end out
  rp_analog_pkg::sample_t ctrl_a, ctrl_b;      // Controller out
  rp_analog_pkg::sample_t dac_sum_a, dac_sum_b;  // Back to the front end in loopback

  housekeeping_regs i_regs (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .bus_addr_i     (bus_addr_i),
    .bus_wdata_i    (bus_wdata_i),
    .bus_wen_i      (bus_wen_i),
    .bus_ren_i      (bus_ren_i),
    .bus_rdata_o    (bus_rdata_o),
    .bus_ack_o      (bus_ack_o),
    .bus_err_o      (bus_err_o),
    .digital_loop_o (digital_loop),
    .level_a_o      (level_a),
    .level_b_o      (level_b),
    .setpt_a_o      (setpt_a),
    .setpt_b_o      (setpt_b),
    .gain_a_o       (gain_a),
    .gain_b_o       (gain_b)
  );

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dac_sum_a),
    .loop_b_i       (dac_sum_b),
    .sample_a_o     (sample_a),
    .sample_b_o     (sample_b)
  );

  p_controller #(
    .GAIN_SHIFT (GAIN_SHIFT)
  ) i_ctrl (
    .adc_clk    (adc_clk),
    .rst_i      (rst_i),
    .sample_a_i (sample_a),
    .sample_b_i (sample_b),
    .setpt_a_i  (setpt_a),
    .setpt_b_i  (setpt_b),
    .gain_a_i   (gain_a),
    .gain_b_i   (gain_b),
    .ctrl_a_o   (ctrl_a),
    .ctrl_b_o   (ctrl_b)
  );

  dac_mixer i_mix (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .level_a_i   (level_a),
    .level_b_i   (level_b),
    .ctrl_a_i    (ctrl_a),
    .ctrl_b_i    (ctrl_b),
    .dac_sum_a_o (dac_sum_a),
    .dac_sum_b_o (dac_sum_b),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o)
  );

endmodule

`default_nettype wire

//--- hw/dac_mixer.sv
// DAC mixer adding generator level and controller output, clipped and encoded
`default_nettype none

module dac_mixer (
  input  wire                       adc_clk,
  input  wire                       rst_i,
  input  rp_analog_pkg::sample_t    level_a_i,    // Constant generator level A
  input  rp_analog_pkg::sample_t    level_b_i,
  input  rp_analog_pkg::sample_t    ctrl_a_i,     // Controller output A
  input  rp_analog_pkg::sample_t    ctrl_b_i,
  output rp_analog_pkg::sample_t    dac_sum_a_o,  // Registered signed sum, for loopback
  output rp_analog_pkg::sample_t    dac_sum_b_o,
  output rp_analog_pkg::dac_code_t  dac_a_o,      // Converter code A
  output rp_analog_pkg::dac_code_t  dac_b_o
);

  localparam int SUM_W = rp_analog_pkg::SAMPLE_W + 1;  // One guard bit

  // Level plus controller, then clip back to a sample
  function automatic rp_analog_pkg::sample_t mix(
    input rp_analog_pkg::sample_t level,
    input rp_analog_pkg::sample_t ctrl
  );
    logic signed [SUM_W-1:0] sum;
    sum = level + ctrl;
    return rp_analog_pkg::sat_sample(sum);
  endfunction

  rp_analog_pkg::sample_t mix_a;
  rp_analog_pkg::sample_t mix_b;

  assign mix_a = mix(level_a_i, ctrl_a_i);
  assign mix_b = mix(level_b_i, ctrl_b_i);

  //////////////////////////////////////////////////
  // Sum register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_sum_a_o <= '0;  // Signed zero
      dac_sum_b_o <= '0;
    end
    else
    begin
      dac_sum_a_o <= mix_a;
      dac_sum_b_o <= mix_b;
    end
  end

  // Back to negative-slope code; zero sum gives 0x1FFF
  assign dac_a_o = rp_analog_pkg::sample_to_code(dac_sum_a_o);
  assign dac_b_o = rp_analog_pkg::sample_to_code(dac_sum_b_o);

endmodule

`default_nettype wire

//--- hw/housekeeping_regs.sv
// Housekeeping registers on the system bus, ID, loopback and channel settings
`default_nettype none

module housekeeping_regs (
  input  wire                                   adc_clk,
  input  wire                                   rst_i,
  // System bus
  input  wire  [rp_analog_pkg::BUS_AW-1:0]      bus_addr_i,   // Byte offset
  input  wire  [rp_analog_pkg::BUS_DW-1:0]      bus_wdata_i,
  input  wire                                   bus_wen_i,    // Single-cycle write pulse
  input  wire                                   bus_ren_i,    // Single-cycle read pulse
  output logic [rp_analog_pkg::BUS_DW-1:0]      bus_rdata_o,  // Valid with ack
  output logic                                  bus_ack_o,
  output logic                                  bus_err_o,
  // Configuration
  output logic                                  digital_loop_o,
  output rp_analog_pkg::sample_t                level_a_o,
  output rp_analog_pkg::sample_t                level_b_o,
  output rp_analog_pkg::sample_t                setpt_a_o,
  output rp_analog_pkg::sample_t                setpt_b_o,
  output rp_analog_pkg::gain_t                  gain_a_o,
  output rp_analog_pkg::gain_t                  gain_b_o
);

  localparam int DW    = rp_analog_pkg::BUS_DW;
  localparam int SMP_W = rp_analog_pkg::SAMPLE_W;
  localparam int GN_W  = rp_analog_pkg::GAIN_W;

  logic          addr_hit;    // Offset is mapped
  logic          addr_is_id;  // Read-only ID offset
  logic [DW-1:0] rd_val;      // Read mux output

  // Sign-extend a sample to bus width
  function automatic logic [DW-1:0] sext_smp(input rp_analog_pkg::sample_t v);
    return {{(DW-SMP_W){v[SMP_W-1]}}, v};
  endfunction

  // Same for gains
  function automatic logic [DW-1:0] sext_gain(input rp_analog_pkg::gain_t v);
    return {{(DW-GN_W){v[GN_W-1]}}, v};
  endfunction

  //////////////////////////////////////////////////
  // Address decode and read mux
  //////////////////////////////////////////////////

  always_comb
  begin
    addr_hit = 1'b1;
    rd_val   = '0;
    case (bus_addr_i)
      rp_analog_pkg::REG_ID:      rd_val = rp_analog_pkg::ID_VALUE;
      rp_analog_pkg::REG_CFG:     rd_val = {{(DW-1){1'b0}}, digital_loop_o};  // Zero-extended
      rp_analog_pkg::REG_LEVEL_A: rd_val = sext_smp(level_a_o);
      rp_analog_pkg::REG_LEVEL_B: rd_val = sext_smp(level_b_o);
      rp_analog_pkg::REG_SETPT_A: rd_val = sext_smp(setpt_a_o);
      rp_analog_pkg::REG_SETPT_B: rd_val = sext_smp(setpt_b_o);
      rp_analog_pkg::REG_GAIN_A:  rd_val = sext_gain(gain_a_o);
      rp_analog_pkg::REG_GAIN_B:  rd_val = sext_gain(gain_b_o);
      default:                    addr_hit = 1'b0;  // Unmapped
    endcase
  end

  assign addr_is_id = (bus_addr_i == rp_analog_pkg::REG_ID);

  //////////////////////////////////////////////////
  // Bus response and register writes
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      bus_ack_o      <= 1'b0;
      bus_err_o      <= 1'b0;
      bus_rdata_o    <= '0;
      digital_loop_o <= 1'b0;
      level_a_o      <= '0;
      level_b_o      <= '0;
      setpt_a_o      <= '0;
      setpt_b_o      <= '0;
      gain_a_o       <= '0;  // Zero gain, controller idle
      gain_b_o       <= '0;
    end
    else
    begin
      // Answer every access on the next edge
      bus_ack_o <= bus_wen_i | bus_ren_i;
      // Unmapped offset, or an attempt to overwrite the ID
      bus_err_o <= (bus_wen_i | bus_ren_i) & (~addr_hit | (bus_wen_i & addr_is_id));

      if (bus_ren_i)
        bus_rdata_o <= rd_val;

      if (bus_wen_i)
      begin
        case (bus_addr_i)
          rp_analog_pkg::REG_CFG:     digital_loop_o <= bus_wdata_i[0];
          rp_analog_pkg::REG_LEVEL_A: level_a_o      <= bus_wdata_i[SMP_W-1:0];
          rp_analog_pkg::REG_LEVEL_B: level_b_o      <= bus_wdata_i[SMP_W-1:0];
          rp_analog_pkg::REG_SETPT_A: setpt_a_o      <= bus_wdata_i[SMP_W-1:0];
          rp_analog_pkg::REG_SETPT_B: setpt_b_o      <= bus_wdata_i[SMP_W-1:0];
          rp_analog_pkg::REG_GAIN_A:  gain_a_o       <= bus_wdata_i[GN_W-1:0];
          rp_analog_pkg::REG_GAIN_B:  gain_b_o       <= bus_wdata_i[GN_W-1:0];
          default:
          begin
            // ID and unmapped offsets, write dropped
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/p_controller.sv
// Two-channel proportional controller, gain times error with shift and clip
`default_nettype none

module p_controller #(
  parameter int GAIN_SHIFT = 10  // Right shift after the gain multiply
) (
  input  wire                       adc_clk,
  input  wire                       rst_i,
  input  rp_analog_pkg::sample_t    sample_a_i,  // Converted ADC sample A
  input  rp_analog_pkg::sample_t    sample_b_i,
  input  rp_analog_pkg::sample_t    setpt_a_i,   // Setpoint A
  input  rp_analog_pkg::sample_t    setpt_b_i,
  input  rp_analog_pkg::gain_t      gain_a_i,    // Signed gain A
  input  rp_analog_pkg::gain_t      gain_b_i,
  output rp_analog_pkg::sample_t    ctrl_a_o,    // Controller output A
  output rp_analog_pkg::sample_t    ctrl_b_o
);

  // Error keeps one extra bit so setpoint minus sample never wraps
  localparam int ERR_W  = rp_analog_pkg::SAMPLE_W + 1;
  localparam int PROD_W = ERR_W + rp_analog_pkg::GAIN_W;  // Full product width

  //////////////////////////////////////////////////
  // Per-channel proportional term
  //////////////////////////////////////////////////

  function automatic rp_analog_pkg::sample_t p_term(
    input rp_analog_pkg::sample_t smp,
    input rp_analog_pkg::sample_t setpt,
    input rp_analog_pkg::gain_t   gain
  );
    logic signed [ERR_W-1:0]  err;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] scaled;
    err    = setpt - smp;             // Both sign-extended first
    prod   = err * gain;              // Signed multiply, no overflow
    scaled = prod >>> GAIN_SHIFT;     // Arithmetic, keeps the sign
    // Clip to +8191 / -8192
    return rp_analog_pkg::sat_sample(scaled);
  endfunction

  rp_analog_pkg::sample_t p_a;  // Unregistered results
  rp_analog_pkg::sample_t p_b;

  assign p_a = p_term(sample_a_i, setpt_a_i, gain_a_i);
  assign p_b = p_term(sample_b_i, setpt_b_i, gain_b_i);

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ctrl_a_o <= '0;
      ctrl_b_o <= '0;
    end
    else
    begin
      ctrl_a_o <= p_a;  // One cycle after the sample
      ctrl_b_o <= p_b;
    end
  end

endmodule

`default_nettype wire

//--- hw/rp_analog_pkg.sv
// Analog path package with sample types, bus register map and sample saturation
`default_nettype none

package rp_analog_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;  // Raw ADC word, two reserved LSBs
  localparam int SAMPLE_W  = 14;  // Converted sample
  localparam int GAIN_W    = 16;  // Controller gain
  localparam int BUS_AW    = 8;   // System bus address
  localparam int BUS_DW    = 32;  // System bus data
  localparam int SAT_W     = 32;  // Widest value the saturation accepts

  typedef logic signed [SAMPLE_W-1:0] sample_t;    // Two's complement sample
  typedef logic        [SAMPLE_W-1:0] dac_code_t;  // Negative-slope converter code
  typedef logic signed [GAIN_W-1:0]   gain_t;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam logic [BUS_AW-1:0] REG_ID      = 8'h00;
  localparam logic [BUS_AW-1:0] REG_CFG     = 8'h04;  // Bit 0 is digital loopback
  localparam logic [BUS_AW-1:0] REG_LEVEL_A = 8'h08;
  localparam logic [BUS_AW-1:0] REG_LEVEL_B = 8'h0C;
  localparam logic [BUS_AW-1:0] REG_SETPT_A = 8'h10;
  localparam logic [BUS_AW-1:0] REG_SETPT_B = 8'h14;
  localparam logic [BUS_AW-1:0] REG_GAIN_A  = 8'h18;
  localparam logic [BUS_AW-1:0] REG_GAIN_B  = 8'h1C;

  localparam logic [BUS_DW-1:0] ID_VALUE = 32'h5250_0100;

  // Sample range limits, +8191 and -8192
  localparam logic signed [SAT_W-1:0] SAMPLE_MAX = 2**(SAMPLE_W-1) - 1;
  localparam logic signed [SAT_W-1:0] SAMPLE_MIN = -(2**(SAMPLE_W-1));

  // Clip any wider signed value into the sample range
  function automatic sample_t sat_sample(input logic signed [SAT_W-1:0] v);
    if (v > SAMPLE_MAX)
      return SAMPLE_MAX[SAMPLE_W-1:0];
    else if (v < SAMPLE_MIN)
      return SAMPLE_MIN[SAMPLE_W-1:0];
    return v[SAMPLE_W-1:0];
  endfunction

  // Negative-slope offset code to two's complement, MSB kept
  function automatic sample_t code_to_sample(input dac_code_t c);
    return {c[SAMPLE_W-1], ~c[SAMPLE_W-2:0]};
  endfunction

  // Reverse direction, same bit flip
  function automatic dac_code_t sample_to_code(input sample_t s);
    return {s[SAMPLE_W-1], ~s[SAMPLE_W-2:0]};
  endfunction

endpackage

`default_nettype wire
